// File: hdl/alu_class_counter.sv
/*
  Leaky error counters of one ALU lane, one per operation class.
  Only the class of the current op moves, all others hold.
  Counts saturate at the top of the counter range.
  A fault flag is sticky until reset and keeps its counter at 0.
  The fault event is a one-cycle pulse registered with the flag.
*/
`include "alu_ft_macros.svh"

module alu_class_counter (
  input  logic                              clock_gated,
  input  logic                              rst_n,
  input  logic                              lane_en_i,
  input  alu_ft_pkg::op_class_e             lane_class_i,
  input  logic                              lane_err_i,
  input  logic                              lane_div_ok_i,
  output logic [`ALU_FT_CNT_W-1:0]          count_o [`ALU_FT_NUM_CLASSES],
  output logic [`ALU_FT_NUM_CLASSES-1:0]    fault_flags_o,
  output logic                              fault_event_o
);

  logic [`ALU_FT_CNT_W-1:0]       cnt_q [`ALU_FT_NUM_CLASSES];
  logic [`ALU_FT_CNT_W-1:0]       cnt_d [`ALU_FT_NUM_CLASSES];
  logic [`ALU_FT_NUM_CLASSES-1:0] flag_q;
  logic [`ALU_FT_NUM_CLASSES-1:0] flag_d;
  logic                           event_q;
  logic                           upd_en;

  //////////////////////////////
  // One leaky step
  //////////////////////////////

  // Error adds INC with saturation; a clean result leaks, small counts drop to 0
  function automatic logic [`ALU_FT_CNT_W-1:0] leak_step(
    input logic [`ALU_FT_CNT_W-1:0] cnt,
    input logic                     err
  );
    logic [`ALU_FT_CNT_W:0] sum;
    sum = {1'b0, cnt} + (`ALU_FT_CNT_W+1)'(`ALU_FT_INC);
    if (err) begin
      if (sum[`ALU_FT_CNT_W]) begin
        leak_step = {`ALU_FT_CNT_W{1'b1}};
      end else begin
        leak_step = sum[`ALU_FT_CNT_W-1:0];
      end
    end else if (cnt > (`ALU_FT_CNT_W)'(2)) begin
      leak_step = cnt - (`ALU_FT_CNT_W)'(`ALU_FT_DEC);
    end else begin
      leak_step = '0;
    end
  endfunction

  //////////////////////////////
  // Next state
  //////////////////////////////

  assign upd_en = lane_en_i && (lane_class_i != alu_ft_pkg::CLS_NONE);

  always_comb begin
    cnt_d  = cnt_q;
    flag_d = flag_q;
    for (int c = 0; c < `ALU_FT_NUM_CLASSES; c++) begin
      if (upd_en && (lane_class_i == alu_ft_pkg::op_class_e'(c))) begin
        if (flag_q[c]) begin
          // Already faulty, nothing left to count
          cnt_d[c] = '0;
        end else if ((lane_class_i != alu_ft_pkg::CLS_DIV) || lane_div_ok_i) begin
          cnt_d[c] = leak_step(cnt_q[c], lane_err_i);
          if (cnt_d[c] >= `ALU_FT_THRESHOLD) begin
            flag_d[c] = 1'b1;
            cnt_d[c]  = '0;
          end
        end
        // Divider still busy: result not final, counter holds
      end
    end
  end

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '{default: '0};
      flag_q  <= '0;
      event_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      flag_q  <= flag_d;
      // Pulse on any rising flag of this lane
      event_q <= |(flag_d & ~flag_q);
    end
  end

  assign count_o       = cnt_q;
  assign fault_flags_o = flag_q;
  assign fault_event_o = event_q;

endmodule

// File: hdl/alu_err_monitor.sv
/*
  Fault monitor for the parallel ALU lanes of the core.
  Lane inputs are taken every cycle, there is no back-pressure.
  Counters and flags update one edge after the classifier samples the op.
  Flags are sticky until rst_n; the read port is free to use every cycle.
*/
`include "alu_ft_macros.svh"

module alu_err_monitor (
  input  logic                                                 clock_gated,
  input  logic                                                 rst_n,
  input  logic [`ALU_FT_NUM_ALU-1:0]                           alu_en_i,
  input  alu_ft_pkg::alu_op_e                                  alu_op_i [`ALU_FT_NUM_ALU],
  input  logic [`ALU_FT_NUM_ALU-1:0]                           err_det_i,
  input  logic                                                 div_ready_i,
  input  logic                                                 rd_en_i,
  input  logic [`ALU_FT_ADDR_W-1:0]                            rd_addr_i,
  output logic [`ALU_FT_NUM_ALU-1:0][`ALU_FT_NUM_CLASSES-1:0]  fault_flags_o,
  output logic [`ALU_FT_NUM_ALU-1:0]                           fault_event_o,
  output logic                                                 rd_valid_o,
  output logic [`ALU_FT_CNT_W-1:0]                             rd_data_o
);

  logic [`ALU_FT_NUM_ALU-1:0] lane_en;
  alu_ft_pkg::op_class_e      lane_class [`ALU_FT_NUM_ALU];
  logic [`ALU_FT_NUM_ALU-1:0] lane_err;
  logic                       lane_div_ok;
  logic [`ALU_FT_CNT_W-1:0]   lane_count [`ALU_FT_NUM_ALU][`ALU_FT_NUM_CLASSES];

  //////////////////////////////
  // Input stage
  //////////////////////////////

  alu_op_classifier i_alu_op_classifier (
    .clock_gated   (clock_gated),
    .rst_n         (rst_n),
    .alu_en_i      (alu_en_i),
    .alu_op_i      (alu_op_i),
    .err_det_i     (err_det_i),
    .div_ready_i   (div_ready_i),
    .lane_en_o     (lane_en),
    .lane_class_o  (lane_class),
    .lane_err_o    (lane_err),
    .lane_div_ok_o (lane_div_ok)
  );

  //////////////////////////////
  // Counter bank per lane
  //////////////////////////////

  for (genvar l = 0; l < `ALU_FT_NUM_ALU; l++) begin : g_lane
    alu_class_counter i_alu_class_counter (
      .clock_gated   (clock_gated),
      .rst_n         (rst_n),
      .lane_en_i     (lane_en[l]),
      .lane_class_i  (lane_class[l]),
      .lane_err_i    (lane_err[l]),
      .lane_div_ok_i (lane_div_ok),
      .count_o       (lane_count[l]),
      .fault_flags_o (fault_flags_o[l]),
      .fault_event_o (fault_event_o[l])
    );
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  alu_fault_readout i_alu_fault_readout (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .count_i     (lane_count),
    .rd_en_i     (rd_en_i),
    .rd_addr_i   (rd_addr_i),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o)
  );

endmodule

// File: hdl/alu_fault_readout.sv
/*
  Registered read port over all lane counters.
  Address = class * NUM_ALU + lane, lane in the low bits.
  Addresses past the last counter read 0, still with valid high.
  Data shows the counts as they stood before the sampling edge.
*/
`include "alu_ft_macros.svh"

module alu_fault_readout (
  input  logic                      clock_gated,
  input  logic                      rst_n,
  input  logic [`ALU_FT_CNT_W-1:0]  count_i [`ALU_FT_NUM_ALU][`ALU_FT_NUM_CLASSES],
  input  logic                      rd_en_i,
  input  logic [`ALU_FT_ADDR_W-1:0] rd_addr_i,
  output logic                      rd_valid_o,
  output logic [`ALU_FT_CNT_W-1:0]  rd_data_o
);

  localparam int unsigned lane_w   = $clog2(`ALU_FT_NUM_ALU);
  localparam int unsigned cls_w    = `ALU_FT_ADDR_W - lane_w;
  localparam int unsigned map_size = `ALU_FT_NUM_ALU * `ALU_FT_NUM_CLASSES;

  logic [lane_w-1:0]        rd_lane;
  logic [cls_w-1:0]         rd_cls;
  logic                     rd_in_map;
  logic [`ALU_FT_CNT_W-1:0] rd_sel;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign rd_lane   = rd_addr_i[lane_w-1:0];
  assign rd_cls    = rd_addr_i[`ALU_FT_ADDR_W-1:lane_w];
  assign rd_in_map = (rd_addr_i < map_size);

  always_comb begin
    rd_sel = '0;
    if (rd_in_map) begin
      rd_sel = count_i[rd_lane][rd_cls];
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  // Data only loads on a read
  always_ff @(posedge clock_gated) begin
    if (rd_en_i) begin
      rd_data_o <= rd_sel;
    end
  end

endmodule

// File: hdl/alu_ft_macros.svh
/*
  Sizing and policy constants of the ALU fault monitor.
  THRESHOLD must fit in CNT_W bits, or no flag can ever rise.
  ADDR_W must cover NUM_ALU * NUM_CLASSES read addresses.
  NUM_ALU is assumed to be a power of two, because the lane index sits
  in the low address bits.
*/
`ifndef ALU_FT_MACROS_SVH
`define ALU_FT_MACROS_SVH

//////////////////////////////
// Array sizes
//////////////////////////////

`define ALU_FT_NUM_ALU      4
`define ALU_FT_NUM_CLASSES  9
`define ALU_FT_CNT_W        8
`define ALU_FT_ADDR_W       6

//////////////////////////////
// Leaky counter policy
//////////////////////////////

// Count at which a class is declared permanently faulty
`define ALU_FT_THRESHOLD    12
// Step per detected error
`define ALU_FT_INC          4
// Step per clean result when the count is above 2
`define ALU_FT_DEC          1

`endif

// File: hdl/alu_ft_pkg.sv
/*
  Types shared by the ALU fault monitor.
  Only the subset of core opcodes that the monitor classifies is listed.
  Any other 7-bit value is treated as unknown and maps to CLS_NONE.
*/
package alu_ft_pkg;

  //////////////////////////////
  // Opcodes known to the monitor
  //////////////////////////////

  typedef enum logic [6:0] {
    // Add and shift
    ALU_ADD   = 7'b0011000,
    ALU_SUB   = 7'b0011001,
    ALU_SRA   = 7'b0100100,
    ALU_SLL   = 7'b0100111,
    // Logic
    ALU_XOR   = 7'b0101111,
    ALU_OR    = 7'b0101110,
    ALU_AND   = 7'b0010101,
    // Bit manipulation
    ALU_BEXT  = 7'b0101000,
    ALU_BSET  = 7'b0101100,
    ALU_BCLR  = 7'b0101101,
    // Bit counting
    ALU_FF1   = 7'b0110110,
    ALU_CNT   = 7'b0110100,
    // Shuffle and pack
    ALU_SHUF  = 7'b0111010,
    ALU_PCKLO = 7'b0111000,
    // Comparison
    ALU_LTS   = 7'b0000000,
    ALU_EQ    = 7'b0001100,
    // Absolute value and clip
    ALU_ABS   = 7'b0010100,
    ALU_CLIP  = 7'b0010110,
    // Min and max
    ALU_MIN   = 7'b0010000,
    ALU_MAX   = 7'b0010010,
    // Divider, result valid only with the divider ready
    ALU_DIV   = 7'b0110001,
    ALU_REM   = 7'b0110011
  } alu_op_e;

  //////////////////////////////
  // Operation classes
  //////////////////////////////

  // The value doubles as the counter index inside a lane
  typedef enum logic [3:0] {
    CLS_SHIFT  = 4'd0,
    CLS_LOGIC  = 4'd1,
    CLS_BITMAN = 4'd2,
    CLS_BITCNT = 4'd3,
    CLS_SHUF   = 4'd4,
    CLS_CMP    = 4'd5,
    CLS_ABS    = 4'd6,
    CLS_MINMAX = 4'd7,
    CLS_DIV    = 4'd8,
    CLS_NONE   = 4'd15
  } op_class_e;

endpackage

// File: hdl/alu_op_classifier.sv
/*
  Input stage of the fault monitor.
  Samples every lane each cycle, there is no stall.
  One divider ready bit is shared by all lanes.
  Unknown opcodes are passed on as CLS_NONE and are ignored downstream.
*/
`include "alu_ft_macros.svh"

module alu_op_classifier (
  input  logic                          clock_gated,
  input  logic                          rst_n,
  input  logic [`ALU_FT_NUM_ALU-1:0]    alu_en_i,
  input  alu_ft_pkg::alu_op_e           alu_op_i [`ALU_FT_NUM_ALU],
  input  logic [`ALU_FT_NUM_ALU-1:0]    err_det_i,
  input  logic                          div_ready_i,
  output logic [`ALU_FT_NUM_ALU-1:0]    lane_en_o,
  output alu_ft_pkg::op_class_e         lane_class_o [`ALU_FT_NUM_ALU],
  output logic [`ALU_FT_NUM_ALU-1:0]    lane_err_o,
  output logic                          lane_div_ok_o
);

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  function automatic alu_ft_pkg::op_class_e op_to_class(input alu_ft_pkg::alu_op_e op);
    case (op)
      alu_ft_pkg::ALU_ADD, alu_ft_pkg::ALU_SUB,
      alu_ft_pkg::ALU_SRA, alu_ft_pkg::ALU_SLL:    op_to_class = alu_ft_pkg::CLS_SHIFT;
      alu_ft_pkg::ALU_XOR, alu_ft_pkg::ALU_OR,
      alu_ft_pkg::ALU_AND:                         op_to_class = alu_ft_pkg::CLS_LOGIC;
      alu_ft_pkg::ALU_BEXT, alu_ft_pkg::ALU_BSET,
      alu_ft_pkg::ALU_BCLR:                        op_to_class = alu_ft_pkg::CLS_BITMAN;
      alu_ft_pkg::ALU_FF1, alu_ft_pkg::ALU_CNT:    op_to_class = alu_ft_pkg::CLS_BITCNT;
      alu_ft_pkg::ALU_SHUF, alu_ft_pkg::ALU_PCKLO: op_to_class = alu_ft_pkg::CLS_SHUF;
      alu_ft_pkg::ALU_LTS, alu_ft_pkg::ALU_EQ:     op_to_class = alu_ft_pkg::CLS_CMP;
      alu_ft_pkg::ALU_ABS, alu_ft_pkg::ALU_CLIP:   op_to_class = alu_ft_pkg::CLS_ABS;
      alu_ft_pkg::ALU_MIN, alu_ft_pkg::ALU_MAX:    op_to_class = alu_ft_pkg::CLS_MINMAX;
      alu_ft_pkg::ALU_DIV, alu_ft_pkg::ALU_REM:    op_to_class = alu_ft_pkg::CLS_DIV;
      default:                                     op_to_class = alu_ft_pkg::CLS_NONE;
    endcase
  endfunction

  //////////////////////////////
  // Pipeline register
  //////////////////////////////

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      lane_en_o     <= '0;
      lane_err_o    <= '0;
      lane_div_ok_o <= 1'b0;
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        lane_class_o[l] <= alu_ft_pkg::CLS_NONE;
      end
    end else begin
      lane_en_o     <= alu_en_i;
      lane_err_o    <= err_det_i;
      // Divider state travels with the op it belongs to
      lane_div_ok_o <= div_ready_i;
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        lane_class_o[l] <= op_to_class(alu_op_i[l]);
      end
    end
  end

endmodule

// File: sim/alu_err_monitor_tb.sv
/*
  Self-checking testbench for the ALU fault monitor.
  Inputs change 0.5 ns after the rising edge; outputs are compared on the falling edge.
  The reference model tracks counters, flags, events and read data cycle by cycle.
  Random traffic keeps every count below the threshold, flags are only hit on purpose.
  The run stops at the first mismatch.
*/
`include "alu_ft_macros.svh"

module alu_err_monitor_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int len_reset  = 16 + 66;
  localparam int len_random = 400 + 66;
  localparam int len_thresh = 16;
  localparam int len_div    = 14;
  localparam int len_indep  = 72;
  localparam int cycle_limit =
    2 * (len_reset + len_random + len_thresh + len_div + len_indep) + 100;
  localparam int map_size  = `ALU_FT_NUM_ALU * `ALU_FT_NUM_CLASSES;
  localparam int num_addr  = 1 << `ALU_FT_ADDR_W;
  // A count below this limit cannot reach threshold with two errors in flight
  localparam int err_limit = `ALU_FT_THRESHOLD - 2 * `ALU_FT_INC;

  logic                                                 clock_gated = 1'b0;
  logic                                                 rst_n;
  logic [`ALU_FT_NUM_ALU-1:0]                           alu_en;
  alu_ft_pkg::alu_op_e                                  alu_op [`ALU_FT_NUM_ALU];
  logic [`ALU_FT_NUM_ALU-1:0]                           err_det;
  logic                                                 div_ready;
  logic                                                 rd_en;
  logic [`ALU_FT_ADDR_W-1:0]                            rd_addr;
  logic [`ALU_FT_NUM_ALU-1:0][`ALU_FT_NUM_CLASSES-1:0]  fault_flags;
  logic [`ALU_FT_NUM_ALU-1:0]                           fault_event;
  logic                                                 rd_valid;
  logic [`ALU_FT_CNT_W-1:0]                             rd_data;

  // Reference model state
  logic [`ALU_FT_CNT_W-1:0]       m_cnt [`ALU_FT_NUM_ALU][`ALU_FT_NUM_CLASSES];
  logic [`ALU_FT_NUM_CLASSES-1:0] m_flag [`ALU_FT_NUM_ALU];
  logic [`ALU_FT_NUM_ALU-1:0]     m_event;
  logic                           m_rd_valid;
  logic [`ALU_FT_CNT_W-1:0]       m_rd_data;
  logic [`ALU_FT_ADDR_W-1:0]      m_rd_addr;
  // Op captured at the last edge, applied at the next one
  logic [`ALU_FT_NUM_ALU-1:0]     s_en;
  logic [`ALU_FT_NUM_ALU-1:0]     s_err;
  logic                           s_div;
  alu_ft_pkg::op_class_e          s_cls [`ALU_FT_NUM_ALU];

  logic        cmp_on = 1'b0;
  int          errors = 0;
  int          cycles = 0;
  int          ev_seen [`ALU_FT_NUM_ALU];
  logic [31:0] rng = 32'h6cbb;

  alu_ft_pkg::alu_op_e known_ops [22] = '{
    alu_ft_pkg::ALU_ADD, alu_ft_pkg::ALU_SUB, alu_ft_pkg::ALU_SRA, alu_ft_pkg::ALU_SLL,
    alu_ft_pkg::ALU_XOR, alu_ft_pkg::ALU_OR, alu_ft_pkg::ALU_AND, alu_ft_pkg::ALU_BEXT,
    alu_ft_pkg::ALU_BSET, alu_ft_pkg::ALU_BCLR, alu_ft_pkg::ALU_FF1, alu_ft_pkg::ALU_CNT,
    alu_ft_pkg::ALU_SHUF, alu_ft_pkg::ALU_PCKLO, alu_ft_pkg::ALU_LTS, alu_ft_pkg::ALU_EQ,
    alu_ft_pkg::ALU_ABS, alu_ft_pkg::ALU_CLIP, alu_ft_pkg::ALU_MIN, alu_ft_pkg::ALU_MAX,
    alu_ft_pkg::ALU_DIV, alu_ft_pkg::ALU_REM
  };

  alu_err_monitor i_alu_err_monitor (
    .clock_gated   (clock_gated),
    .rst_n         (rst_n),
    .alu_en_i      (alu_en),
    .alu_op_i      (alu_op),
    .err_det_i     (err_det),
    .div_ready_i   (div_ready),
    .rd_en_i       (rd_en),
    .rd_addr_i     (rd_addr),
    .fault_flags_o (fault_flags),
    .fault_event_o (fault_event),
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data)
  );

  always #2 clock_gated = ~clock_gated;

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  function logic [31:0] lcg_next();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  function automatic alu_ft_pkg::op_class_e ref_class(input alu_ft_pkg::alu_op_e op);
    case (op)
      alu_ft_pkg::ALU_ADD, alu_ft_pkg::ALU_SUB,
      alu_ft_pkg::ALU_SRA, alu_ft_pkg::ALU_SLL:    return alu_ft_pkg::CLS_SHIFT;
      alu_ft_pkg::ALU_XOR, alu_ft_pkg::ALU_OR,
      alu_ft_pkg::ALU_AND:                         return alu_ft_pkg::CLS_LOGIC;
      alu_ft_pkg::ALU_BEXT, alu_ft_pkg::ALU_BSET,
      alu_ft_pkg::ALU_BCLR:                        return alu_ft_pkg::CLS_BITMAN;
      alu_ft_pkg::ALU_FF1, alu_ft_pkg::ALU_CNT:    return alu_ft_pkg::CLS_BITCNT;
      alu_ft_pkg::ALU_SHUF, alu_ft_pkg::ALU_PCKLO: return alu_ft_pkg::CLS_SHUF;
      alu_ft_pkg::ALU_LTS, alu_ft_pkg::ALU_EQ:     return alu_ft_pkg::CLS_CMP;
      alu_ft_pkg::ALU_ABS, alu_ft_pkg::ALU_CLIP:   return alu_ft_pkg::CLS_ABS;
      alu_ft_pkg::ALU_MIN, alu_ft_pkg::ALU_MAX:    return alu_ft_pkg::CLS_MINMAX;
      alu_ft_pkg::ALU_DIV, alu_ft_pkg::ALU_REM:    return alu_ft_pkg::CLS_DIV;
      default:                                     return alu_ft_pkg::CLS_NONE;
    endcase
  endfunction

  // Returns {flag, count} after one op on a counter
  function automatic logic [`ALU_FT_CNT_W:0] ref_update(
    input logic [`ALU_FT_CNT_W-1:0] cnt,
    input logic                     flag,
    input logic                     err,
    input logic                     hold
  );
    int nxt;
    if (flag) return {1'b1, {`ALU_FT_CNT_W{1'b0}}};
    if (hold) return {1'b0, cnt};
    if (err) begin
      nxt = int'(cnt) + `ALU_FT_INC;
      if (nxt > (1 << `ALU_FT_CNT_W) - 1) nxt = (1 << `ALU_FT_CNT_W) - 1;
    end else if (cnt > 2) begin
      nxt = int'(cnt) - `ALU_FT_DEC;
    end else begin
      nxt = 0;
    end
    if (nxt >= `ALU_FT_THRESHOLD) return {1'b1, {`ALU_FT_CNT_W{1'b0}}};
    return {1'b0, nxt[`ALU_FT_CNT_W-1:0]};
  endfunction

  function automatic alu_ft_pkg::op_class_e addr_class(input int addr);
    if (addr >= map_size) return alu_ft_pkg::CLS_NONE;
    return alu_ft_pkg::op_class_e'(addr / `ALU_FT_NUM_ALU);
  endfunction

  function automatic logic [`ALU_FT_CNT_W-1:0] ref_read(input int addr);
    if (addr >= map_size) return '0;
    return m_cnt[addr % `ALU_FT_NUM_ALU][addr / `ALU_FT_NUM_ALU];
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic stop_on_error(input string line);
    errors++;
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flags(input int lane, input logic [`ALU_FT_NUM_CLASSES-1:0] got,
                             input logic [`ALU_FT_NUM_CLASSES-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %0t: lane %0d flags %b, expected %b", $time, lane, got, exp));
  endtask

  task automatic check_event(input int lane, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %0t: lane %0d event %b, expected %b", $time, lane, got, exp));
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %0t: read valid %b, expected %b", $time, got, exp));
  endtask

  task automatic check_count(input int lane, input alu_ft_pkg::op_class_e cls,
                             input logic [`ALU_FT_CNT_W-1:0] got,
                             input logic [`ALU_FT_CNT_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %0t: count lane %0d class %s is %0d, expected %0d",
                              $time, lane, cls.name(), got, exp));
  endtask

  //////////////////////////////
  // Model and compare processes
  //////////////////////////////

  always @(posedge clock_gated or negedge rst_n) begin
    logic [`ALU_FT_CNT_W:0] upd;
    int c;
    if (!rst_n) begin
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        for (int k = 0; k < `ALU_FT_NUM_CLASSES; k++) m_cnt[l][k] = '0;
        m_flag[l] = '0;
        s_cls[l]  = alu_ft_pkg::CLS_NONE;
      end
      m_event    = '0;
      m_rd_valid = 1'b0;
      m_rd_data  = '0;
      s_en       = '0;
      s_err      = '0;
      s_div      = 1'b0;
    end else begin
      // Read sees the counts from before this edge
      m_rd_valid = rd_en;
      if (rd_en) begin
        m_rd_addr = rd_addr;
        m_rd_data = ref_read(rd_addr);
      end
      m_event = '0;
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        if (s_en[l] && s_cls[l] != alu_ft_pkg::CLS_NONE) begin
          c   = int'(s_cls[l]);
          upd = ref_update(m_cnt[l][c], m_flag[l][c], s_err[l],
                           s_cls[l] == alu_ft_pkg::CLS_DIV && !s_div);
          if (upd[`ALU_FT_CNT_W] && !m_flag[l][c]) m_event[l] = 1'b1;
          m_flag[l][c] = upd[`ALU_FT_CNT_W];
          m_cnt[l][c]  = upd[`ALU_FT_CNT_W-1:0];
        end
      end
      s_en  = alu_en;
      s_err = err_det;
      s_div = div_ready;
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) s_cls[l] = ref_class(alu_op[l]);
    end
  end

  always @(negedge clock_gated) begin
    if (cmp_on) begin
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        check_flags(l, fault_flags[l], m_flag[l]);
        check_event(l, fault_event[l], m_event[l]);
        if (fault_event[l]) ev_seen[l]++;
      end
      check_valid(rd_valid, m_rd_valid);
      if (m_rd_valid)
        check_count(m_rd_addr % `ALU_FT_NUM_ALU, addr_class(m_rd_addr), rd_data, m_rd_data);
    end
  end

  always @(posedge clock_gated) begin
    cycles++;
    if (cycles >= cycle_limit)
      stop_on_error($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clock_gated);
    #0.5;
  endtask

  task automatic idle_lanes();
    alu_en    = '0;
    err_det   = '0;
    div_ready = 1'b0;
    for (int l = 0; l < `ALU_FT_NUM_ALU; l++) alu_op[l] = alu_ft_pkg::ALU_ADD;
  endtask

  task automatic read_all();
    for (int a = 0; a < num_addr; a++) begin
      rd_en   = 1'b1;
      rd_addr = a[`ALU_FT_ADDR_W-1:0];
      next_cycle();
    end
    rd_en = 1'b0;
    next_cycle();
  endtask

  task automatic drive_one(input int lane, input alu_ft_pkg::alu_op_e op, input logic err,
                           input logic div_rdy, input int reps);
    idle_lanes();
    alu_en[lane]  = 1'b1;
    alu_op[lane]  = op;
    err_det[lane] = err;
    div_ready     = div_rdy;
    repeat (reps) next_cycle();
  endtask

  initial begin
    logic [31:0]           r;
    alu_ft_pkg::alu_op_e   op;
    alu_ft_pkg::op_class_e cls;
    rst_n   = 1'b0;
    rd_en   = 1'b0;
    rd_addr = '0;
    idle_lanes();
    for (int l = 0; l < `ALU_FT_NUM_ALU; l++) ev_seen[l] = 0;
    repeat (16) @(posedge clock_gated);
    #0.5;
    rst_n  = 1'b1;
    cmp_on = 1'b1;

    // Reset state, every address reads 0
    read_all();

    // Random traffic with sparse errors
    for (int i = 0; i < 400; i++) begin
      for (int l = 0; l < `ALU_FT_NUM_ALU; l++) begin
        r         = lcg_next();
        alu_en[l] = (r[31:29] != 3'd0);
        if (r[28:25] == 4'd0) op = alu_ft_pkg::alu_op_e'(7'h7f);
        else op = known_ops[r[24:16] % 22];
        alu_op[l]  = op;
        cls        = ref_class(op);
        err_det[l] = (r[15:13] == 3'd0);
        if (cls != alu_ft_pkg::CLS_NONE && m_cnt[l][cls] >= err_limit) err_det[l] = 1'b0;
      end
      r         = lcg_next();
      div_ready = r[31];
      rd_en     = r[30];
      rd_addr   = r[29:24];
      next_cycle();
    end
    idle_lanes();
    rd_en = 1'b0;
    read_all();

    // Threshold on lane 1 logic class, then further errors
    ev_seen[1] = 0;
    drive_one(1, alu_ft_pkg::ALU_XOR, 1'b1, 1'b0, 8);
    idle_lanes();
    repeat (3) next_cycle();
    if (fault_flags[1][alu_ft_pkg::CLS_LOGIC] !== 1'b1)
      stop_on_error($sformatf("ERR %0t: lane 1 logic flag is not set after repeated errors",
                              $time));
    if (ev_seen[1] != 1)
      stop_on_error($sformatf("ERR %0t: lane 1 fault event pulsed %0d times, expected 1",
                              $time, ev_seen[1]));
    rd_en   = 1'b1;
    rd_addr = alu_ft_pkg::CLS_LOGIC * `ALU_FT_NUM_ALU + 1;
    next_cycle();
    rd_en = 1'b0;

    // Divider gating on lane 2 with the div counter read every cycle
    rd_en   = 1'b1;
    rd_addr = alu_ft_pkg::CLS_DIV * `ALU_FT_NUM_ALU + 2;
    drive_one(2, alu_ft_pkg::ALU_DIV, 1'b1, 1'b0, 2);
    drive_one(2, alu_ft_pkg::ALU_REM, 1'b1, 1'b0, 2);
    drive_one(2, alu_ft_pkg::ALU_REM, 1'b1, 1'b1, 1);
    drive_one(2, alu_ft_pkg::ALU_REM, 1'b0, 1'b1, 2);
    idle_lanes();
    repeat (3) next_cycle();
    rd_en = 1'b0;

    // Lane independence, disabled lanes and unknown opcodes
    idle_lanes();
    alu_en     = 4'b0101;
    err_det    = 4'b1111;
    div_ready  = 1'b1;
    alu_op[0]  = alu_ft_pkg::ALU_LTS;
    alu_op[1]  = alu_ft_pkg::ALU_ADD;
    alu_op[2]  = alu_ft_pkg::alu_op_e'(7'h7f);
    alu_op[3]  = alu_ft_pkg::ALU_DIV;
    repeat (2) next_cycle();
    idle_lanes();
    next_cycle();
    read_all();

    repeat (3) next_cycle();
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/alu_ft_pkg.sv
hdl/alu_op_classifier.sv
hdl/alu_class_counter.sv
hdl/alu_fault_readout.sv
hdl/alu_err_monitor.sv
sim/alu_err_monitor_tb.sv
